// ==== Makefile ====
# Verilator build and run of the load/store testbench.

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/lsu_pkg.sv ====
package lsu_pkg;

        // Data and address width.
        localparam int WORD_W = 32;

        // Default physical register count, also sizes the register index.
        localparam int PHY_REGS_DEF = 46;

        // One data or address word.
        typedef logic [WORD_W-1:0] word_t;

        // Physical register index, 46 registers round up to 6 bits.
        typedef logic [$clog2(PHY_REGS_DEF)-1:0] reg_index_t;

        // Wishbone byte selects, one per byte lane.
        typedef logic [WORD_W/8-1:0] byte_sel_t;

        // Byte lane within a word.
        typedef logic [1:0] lane_t;

        // Access size. The order is the encoding the execute stage uses.
        typedef enum logic [2:0] {
                SIZE_WORD  = 3'd0,
                SIZE_UBYTE = 3'd1,
                SIZE_SBYTE = 3'd2,
                SIZE_UHALF = 3'd3,
                SIZE_SHALF = 3'd4
        } mem_size_e;

        // Operation handed over by the execute stage.
        typedef struct packed {
                logic       valid;
                logic       is_load;
                logic       is_store;
                mem_size_e  size;
                word_t      address;
                word_t      alu_result;
                word_t      store_value;
                reg_index_t dest;
        } ex_op_t;

        // Result handed from the memory stage to writeback.
        typedef struct packed {
                logic       valid;
                reg_index_t dest;
                word_t      value;
                logic       fault;
        } mem_result_t;

        // Data port bus state.
        typedef enum logic {
                PORT_IDLE = 1'b0,
                PORT_BUSY = 1'b1
        } port_state_e;

endpackage

// ==== files.f ====
common/lsu_pkg.sv
hw/mem_access/wb_data_port.sv
hw/mem_access/memory_stage.sv
hw/wb_ram.sv
hw/reg_writeback.sv
hw/lsu_top.sv
test/tb_lsu.sv

// ==== hw/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top #(
        parameter int PHY_REGS  = lsu_pkg::PHY_REGS_DEF,
        parameter int RAM_WORDS = 256,
        parameter int RAM_WAIT  = 1
) (
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_clear,
        input  lsu_pkg::ex_op_t     i_ex,
        output logic                o_stall,
        output logic                o_fault,
        input  lsu_pkg::reg_index_t i_rd_index,
        output lsu_pkg::word_t      o_rd_data
);
        import lsu_pkg::*;

        // Wishbone between port and RAM.
        logic        wb_cyc;
        logic        wb_stb;
        logic        wb_we;
        word_t       wb_adr;
        byte_sel_t   wb_sel;
        word_t       wb_dat_w;
        word_t       wb_dat_r;
        logic        wb_ack;
        logic        wb_err;

        word_t       rd_word;
        logic        port_fault;
        logic        port_done;
        mem_result_t result;

        wb_data_port port_i (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_clear   (i_clear),
                .i_ex      (i_ex),
                .o_stall   (o_stall),
                .o_wb_cyc  (wb_cyc),
                .o_wb_stb  (wb_stb),
                .o_wb_we   (wb_we),
                .o_wb_adr  (wb_adr),
                .o_wb_sel  (wb_sel),
                .o_wb_dat  (wb_dat_w),
                .i_wb_ack  (wb_ack),
                .i_wb_err  (wb_err),
                .i_wb_dat  (wb_dat_r),
                .o_rd_word (rd_word),
                .o_fault   (port_fault),
                .o_done    (port_done)
        );

        wb_ram #(
                .RAM_WORDS (RAM_WORDS),
                .RAM_WAIT  (RAM_WAIT)
        ) ram_i (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_wb_cyc (wb_cyc),
                .i_wb_stb (wb_stb),
                .i_wb_we  (wb_we),
                .i_wb_adr (wb_adr),
                .i_wb_sel (wb_sel),
                .i_wb_dat (wb_dat_w),
                .o_wb_ack (wb_ack),
                .o_wb_err (wb_err),
                .o_wb_dat (wb_dat_r)
        );

        memory_stage mem_i (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_clear   (i_clear),
                .i_stall   (o_stall),
                .i_done    (port_done),
                .i_ex      (i_ex),
                .i_rd_word (rd_word),
                .i_fault   (port_fault),
                .o_result  (result)
        );

        reg_writeback #(
                .PHY_REGS (PHY_REGS)
        ) wb_i (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_result   (result),
                .i_rd_index (i_rd_index),
                .o_rd_data  (o_rd_data)
        );

        assign o_fault = result.fault;

endmodule

// ==== hw/mem_access/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage (
        input  logic                 i_clk,
        input  logic                 i_reset,
        input  logic                 i_clear,
        input  logic                 i_stall,
        input  logic                 i_done,
        input  lsu_pkg::ex_op_t      i_ex,
        input  lsu_pkg::word_t       i_rd_word,
        input  logic                 i_fault,
        output lsu_pkg::mem_result_t o_result
);
        import lsu_pkg::*;

        ex_op_t ex_q;
        logic   valid_q;
        logic   is_mem;
        logic   mem_ready;
        word_t  lane_word;
        word_t  load_value;

        // Valid bit of the buffered op.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        valid_q <= 1'b0;
                else if (i_clear)
                        valid_q <= 1'b0;
                else if (!i_stall)
                        valid_q <= i_ex.valid;
        end

        // Op fields, held through the bus cycle.
        always_ff @(posedge i_clk)
        begin
                if (!i_stall)
                        ex_q <= i_ex;
        end

        assign is_mem = ex_q.is_load || ex_q.is_store;

        // Memory ops wait for the port to finish.
        assign mem_ready = !is_mem || i_done;

        // Bus returns a whole word. Pick the lane, then extend.
        always_comb
        begin
                case (ex_q.size)
                        SIZE_UBYTE, SIZE_SBYTE:
                                lane_word = i_rd_word >> {ex_q.address[1:0], 3'b000};
                        SIZE_UHALF, SIZE_SHALF:
                                lane_word = i_rd_word >> {ex_q.address[1], 4'b0000};
                        default:
                                lane_word = i_rd_word;
                endcase

                case (ex_q.size)
                        SIZE_UBYTE:
                                load_value = {24'd0, lane_word[7:0]};
                        SIZE_SBYTE:
                                load_value = {{24{lane_word[7]}}, lane_word[7:0]};
                        SIZE_UHALF:
                                load_value = {16'd0, lane_word[15:0]};
                        SIZE_SHALF:
                                load_value = {{16{lane_word[15]}}, lane_word[15:0]};
                        default:
                                load_value = lane_word;
                endcase
        end

        always_comb
        begin
                // Stores never write a register.
                o_result.valid = valid_q && mem_ready && !ex_q.is_store;
                o_result.dest  = ex_q.dest;
                o_result.value = ex_q.is_load ? load_value : ex_q.alu_result;
                o_result.fault = valid_q && is_mem && i_done && i_fault;
        end

endmodule

// ==== hw/mem_access/wb_data_port.sv ====
`timescale 1ns/10ps

module wb_data_port (
        input  logic               i_clk,
        input  logic               i_reset,
        input  logic               i_clear,
        input  lsu_pkg::ex_op_t    i_ex,
        output logic               o_stall,
        output logic               o_wb_cyc,
        output logic               o_wb_stb,
        output logic               o_wb_we,
        output lsu_pkg::word_t     o_wb_adr,
        output lsu_pkg::byte_sel_t o_wb_sel,
        output lsu_pkg::word_t     o_wb_dat,
        input  logic               i_wb_ack,
        input  logic               i_wb_err,
        input  lsu_pkg::word_t     i_wb_dat,
        output lsu_pkg::word_t     o_rd_word,
        output logic               o_fault,
        output logic               o_done
);
        import lsu_pkg::*;

        port_state_e state_q;
        logic        start;
        logic        term;
        lane_t       lane;
        byte_sel_t   sel_d;
        word_t       dat_d;

        assign lane = i_ex.address[1:0];

        // New load or store accepted this edge.
        assign start = (state_q == PORT_IDLE) && i_ex.valid &&
                       (i_ex.is_load || i_ex.is_store) && !i_clear;

        // Slave ended the cycle, either way.
        assign term = (state_q == PORT_BUSY) && (i_wb_ack || i_wb_err);

        // Lane selects and store data steered into its lane.
        always_comb
        begin
                case (i_ex.size)
                        SIZE_UBYTE, SIZE_SBYTE:
                        begin
                                sel_d = 4'b0001 << lane;
                                dat_d = i_ex.store_value << {lane, 3'b000};
                        end
                        SIZE_UHALF, SIZE_SHALF:
                        begin
                                sel_d = 4'b0011 << {lane[1], 1'b0};
                                dat_d = i_ex.store_value << {lane[1], 4'b0000};
                        end
                        default:
                        begin
                                sel_d = 4'b1111;
                                dat_d = i_ex.store_value;
                        end
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        state_q <= PORT_IDLE;
                else if (i_clear)
                        state_q <= PORT_IDLE;
                else if (start)
                        state_q <= PORT_BUSY;
                else if (term)
                        state_q <= PORT_IDLE;
        end

        // Request fields stay stable for the whole cycle.
        always_ff @(posedge i_clk)
        begin
                if (start)
                begin
                        o_wb_we  <= i_ex.is_store;
                        o_wb_adr <= {i_ex.address[WORD_W-1:2], 2'b00};
                        o_wb_sel <= sel_d;
                        o_wb_dat <= dat_d;
                end
        end

        // Read word kept until the memory stage has used it.
        always_ff @(posedge i_clk)
        begin
                if (term)
                        o_rd_word <= i_wb_dat;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_fault <= 1'b0;
                        o_done  <= 1'b0;
                end
                else
                begin
                        if (term)
                                o_fault <= i_wb_err;
                        // No done pulse for an aborted cycle.
                        o_done <= term && !i_clear;
                end
        end

        assign o_stall  = (state_q == PORT_BUSY);
        assign o_wb_cyc = (state_q == PORT_BUSY);
        assign o_wb_stb = (state_q == PORT_BUSY);

endmodule

// ==== hw/reg_writeback.sv ====
`timescale 1ns/10ps

module reg_writeback #(
        parameter int PHY_REGS = lsu_pkg::PHY_REGS_DEF
) (
        input  logic                 i_clk,
        input  logic                 i_reset,
        input  lsu_pkg::mem_result_t i_result,
        input  lsu_pkg::reg_index_t  i_rd_index,
        output lsu_pkg::word_t       o_rd_data
);
        import lsu_pkg::*;

        word_t regs [PHY_REGS];
        logic  wr_en;

        // Faulted results leave the register alone.
        assign wr_en = i_result.valid && !i_result.fault &&
                       (int'(i_result.dest) < PHY_REGS);

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int r = 0; r < PHY_REGS; r++)
                                regs[r] <= '0;
                end
                else if (wr_en)
                        regs[i_result.dest] <= i_result.value;
        end

        // Indices past the file read as zero.
        assign o_rd_data = (int'(i_rd_index) < PHY_REGS) ? regs[i_rd_index] : '0;

endmodule

// ==== hw/wb_ram.sv ====
`timescale 1ns/10ps

module wb_ram #(
        parameter int RAM_WORDS = 256,
        parameter int RAM_WAIT  = 1
) (
        input  logic               i_clk,
        input  logic               i_reset,
        input  logic               i_wb_cyc,
        input  logic               i_wb_stb,
        input  logic               i_wb_we,
        input  lsu_pkg::word_t     i_wb_adr,
        input  lsu_pkg::byte_sel_t i_wb_sel,
        input  lsu_pkg::word_t     i_wb_dat,
        output logic               o_wb_ack,
        output logic               o_wb_err,
        output lsu_pkg::word_t     o_wb_dat
);
        import lsu_pkg::*;

        localparam int IDX_W = $clog2(RAM_WORDS);
        localparam int CNT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

        word_t            mem [RAM_WORDS];
        logic [CNT_W-1:0] wait_q;
        logic [IDX_W-1:0] idx;
        logic             req;
        logic             in_range;
        logic             fire;

        // Pending request, not yet answered.
        assign req      = i_wb_cyc && i_wb_stb && !o_wb_ack && !o_wb_err;
        assign in_range = (i_wb_adr[WORD_W-1:2] < RAM_WORDS);
        assign idx      = i_wb_adr[IDX_W+1:2];
        assign fire     = req && (wait_q == CNT_W'(RAM_WAIT));

        // Wait states, restarted when the master drops the cycle.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        wait_q <= '0;
                else if (!req || fire)
                        wait_q <= '0;
                else
                        wait_q <= wait_q + 1'b1;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_wb_ack <= 1'b0;
                        o_wb_err <= 1'b0;
                end
                else
                begin
                        o_wb_ack <= fire && in_range;
                        o_wb_err <= fire && !in_range;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (fire && in_range)
                begin
                        if (i_wb_we)
                        begin
                                for (int b = 0; b < WORD_W / 8; b++)
                                        if (i_wb_sel[b])
                                                mem[idx][8*b +: 8] <= i_wb_dat[8*b +: 8];
                        end
                        else
                                o_wb_dat <= mem[idx];
                end
        end

endmodule

// ==== test/lsu_cases.txt ====
# kind size address value dest expected fault, all hex; value is the store data or ALU result
# kind 0 alu, 1 load, 2 store, 3 load cut by clear, 4 random store, 5 load of random data; size 0 word, 1 ubyte, 2 sbyte, 3 uhalf, 4 shalf
0 0 00000000 12345678 01 12345678 0
0 0 00000000 deadbeef 2d deadbeef 0
2 0 00000010 a1b2c3f4 01 12345678 0
1 0 00000010 00000000 02 a1b2c3f4 0
1 1 00000010 00000000 03 000000f4 0
1 2 00000010 00000000 03 fffffff4 0
1 1 00000011 00000000 04 000000c3 0
1 2 00000012 00000000 04 ffffffb2 0
1 2 00000013 00000000 05 ffffffa1 0
1 1 00000013 00000000 05 000000a1 0
1 3 00000010 00000000 06 0000c3f4 0
1 4 00000012 00000000 06 ffffa1b2 0
2 1 00000011 99887755 08 00000000 0
1 0 00000010 00000000 08 a1b255f4 0
2 4 00000012 cafe7e6d 08 a1b255f4 0
1 0 00000010 00000000 09 7e6d55f4 0
1 4 00000012 00000000 0a 00007e6d 0
1 0 00000400 00000000 02 a1b2c3f4 1
2 0 00001000 11111111 02 a1b2c3f4 1
3 0 00000010 00000000 01 12345678 0
1 0 00000010 00000000 01 7e6d55f4 0
4 0 00000020 00000000 0b 00000000 0
4 0 00000024 00000000 0b 00000000 0
5 0 00000020 00000000 0c 00000000 0
5 2 00000021 00000000 0d 00000000 0
5 3 00000026 00000000 0e 00000000 0
5 4 00000024 00000000 0f 00000000 0
5 1 00000023 00000000 10 00000000 0

// ==== test/tb_lsu.sv ====
`timescale 1ns/10ps

module tb_lsu;
        import lsu_pkg::*;

        localparam int PHY_REGS        = 46;
        localparam int RAM_WORDS       = 256;
        localparam int RAM_WAIT        = 2;
        localparam int RESET_CYCLES    = 5;
        localparam int CYCLES_PER_CASE = 20;
        localparam word_t LFSR_SEED    = 32'hc0912c90;
        localparam word_t LFSR_TAPS    = 32'h80200003;

        // Case kinds as used in the case file.
        localparam int KIND_ALU        = 0;
        localparam int KIND_LOAD       = 1;
        localparam int KIND_STORE      = 2;
        localparam int KIND_CLEAR      = 3;
        localparam int KIND_RAND_STORE = 4;
        localparam int KIND_RAND_LOAD  = 5;

        typedef struct packed {
                logic [3:0] kind;
                mem_size_e  size;
                word_t      address;
                word_t      value;
                reg_index_t dest;
                word_t      expected;
                logic       fault;
        } case_t;

        logic       clk;
        logic       reset;
        logic       clear;
        ex_op_t     ex;
        logic       stall;
        logic       fault;
        reg_index_t rd_index;
        word_t      rd_data;

        case_t cases [$];
        word_t shadow [int];
        word_t lfsr_state;
        logic  cases_ready;

        lsu_top #(
                .PHY_REGS  (PHY_REGS),
                .RAM_WORDS (RAM_WORDS),
                .RAM_WAIT  (RAM_WAIT)
        ) dut_i (
                .i_clk      (clk),
                .i_reset    (reset),
                .i_clear    (clear),
                .i_ex       (ex),
                .o_stall    (stall),
                .o_fault    (fault),
                .i_rd_index (rd_index),
                .o_rd_data  (rd_data)
        );

        initial
        begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        task automatic stop_run(input string what);
                $display("%s", what);
                $display("*** TEST FAILED ***");
                $fatal(1, "Simulation stopped");
        endtask

        function automatic word_t lfsr_step(input word_t s);
                return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
        endfunction

        // One LFSR step per bit taken.
        function automatic word_t random_word();
                word_t w;
                w = '0;
                for (int i = 0; i < 32; i++)
                begin
                        w = {w[30:0], lfsr_state[0]};
                        lfsr_state = lfsr_step(lfsr_state);
                end
                return w;
        endfunction

        // Expected load result from a stored word.
        function automatic word_t lane_value(input word_t w, input mem_size_e size,
                                             input logic [1:0] lane);
                logic [7:0]  b;
                logic [15:0] h;
                b = w[8*int'(lane) +: 8];
                h = lane[1] ? w[31:16] : w[15:0];
                case (size)
                        SIZE_UBYTE: return {24'd0, b};
                        SIZE_SBYTE: return {{24{b[7]}}, b};
                        SIZE_UHALF: return {16'd0, h};
                        SIZE_SHALF: return {{16{h[15]}}, h};
                        default:    return w;
                endcase
        endfunction

        task automatic load_cases();
                int    fd;
                int    n;
                string line;
                word_t f [7];
                case_t c;
                fd = $fopen("test/lsu_cases.txt", "r");
                assert (fd != 0)
                else stop_run("Could not open the case file test/lsu_cases.txt");
                while ($fgets(line, fd) != 0)
                begin
                        // Skip comments and blank lines.
                        if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
                                continue;
                        n = $sscanf(line, "%h %h %h %h %h %h %h",
                                    f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                        assert (n == 7)
                        else stop_run($sformatf("Malformed line in the case file: %s", line));
                        c.kind     = f[0][3:0];
                        c.size     = mem_size_e'(f[1][2:0]);
                        c.address  = f[2];
                        c.value    = f[3];
                        c.dest     = reg_index_t'(f[4]);
                        c.expected = f[5];
                        c.fault    = f[6][0];
                        cases.push_back(c);
                end
                $fclose(fd);
                assert (cases.size() > 0)
                else stop_run("The case file holds no cases");
        endtask

        task automatic run_case(input case_t c, input int num);
                word_t exp_value;
                logic  fault_seen;
                int    idx;
                idx       = int'(c.address[31:2]);
                exp_value = c.expected;

                ex             = '0;
                ex.valid       = 1'b1;
                ex.is_load     = (c.kind == KIND_LOAD) || (c.kind == KIND_CLEAR) ||
                                 (c.kind == KIND_RAND_LOAD);
                ex.is_store    = (c.kind == KIND_STORE) || (c.kind == KIND_RAND_STORE);
                ex.size        = c.size;
                ex.address     = c.address;
                ex.alu_result  = c.value;
                ex.store_value = c.value;
                ex.dest        = c.dest;

                // Random word stores are kept for later loads.
                // The ALU field carries the word too, so a store that writes a register shows.
                if (c.kind == KIND_RAND_STORE)
                begin
                        ex.store_value = random_word();
                        ex.alu_result  = ex.store_value;
                        shadow[idx]    = ex.store_value;
                end
                if (c.kind == KIND_RAND_LOAD)
                begin
                        assert (shadow.exists(idx))
                        else stop_run($sformatf("Case %0d loads a word never stored", num));
                        exp_value = lane_value(shadow[idx], c.size, c.address[1:0]);
                end

                @(negedge clk);
                // Abort the load while its bus cycle is open.
                if (c.kind == KIND_CLEAR)
                begin
                        clear    = 1'b1;
                        ex.valid = 1'b0;
                        @(negedge clk);
                        clear = 1'b0;
                end
                while (stall)
                        @(negedge clk);
                fault_seen = fault;
                ex         = '0;
                repeat (2) @(negedge clk);

                rd_index = c.dest;
                #1;
                assert (fault_seen == c.fault)
                else stop_run($sformatf("FAIL %0t: case %0d fault %b, expected %b",
                                        $time, num, fault_seen, c.fault));
                assert (rd_data == exp_value)
                else stop_run($sformatf("FAIL %0t: case %0d reg %0d read %h, expected %h",
                                        $time, num, c.dest, rd_data, exp_value));
                @(negedge clk);
        endtask

        // Watchdog sized from the case count.
        initial
        begin
                int limit;
                wait (cases_ready);
                limit = cases.size() * CYCLES_PER_CASE + RESET_CYCLES;
                repeat (limit) @(posedge clk);
                stop_run($sformatf("Timeout, the run did not end within %0d cycles", limit));
        end

        initial
        begin
                reset       = 1'b1;
                clear       = 1'b0;
                ex          = '0;
                rd_index    = '0;
                lfsr_state  = LFSR_SEED;
                cases_ready = 1'b0;

                load_cases();
                cases_ready = 1'b1;

                repeat (RESET_CYCLES) @(negedge clk);
                reset = 1'b0;
                assert (!stall && !fault)
                else stop_run($sformatf("FAIL %0t: stall %b fault %b after reset",
                                        $time, stall, fault));

                foreach (cases[i])
                        run_case(cases[i], i);

                $display("*** TEST PASSED ***");
                $finish;
        end

endmodule
